/* dram_phy.f */
+incdir+src
src/dram_pkg.sv
src/edge_det.sv
src/dram_cmd_enc.sv
src/dram_ctrl.sv
src/data_transfer.sv
src/dram_phy_top.sv
tests/dram_model.sv
tests/tb_dram_phy.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the dram_phy testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_dram_phy -Mdir obj_dir -f dram_phy.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_dram_phy > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi

echo "Simulation passed"
exit 0

/* tests/tb_dram_phy.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dram_defines.svh"

module tb_dram_phy;

    localparam int NUM_WR  = 12;
    localparam int NUM_RD  = 16;
    localparam int NUM_REQ = NUM_WR + NUM_RD + 1;
    localparam int ADDR_W  = `DRAM_BANK_W + `DRAM_ROW_W + `DRAM_COL_W;
    localparam int WR_WIN  = `DRAM_CWL + `DRAM_BURST + 3;
    localparam int MAX_WIN = (WR_WIN > `DRAM_RD_WIN) ? WR_WIN : `DRAM_RD_WIN;
    // Accept, ACT, tRCD, issue, data window, PRE, tRP and done
    localparam int REQ_CYC = MAX_WIN + `DRAM_TRCD + `DRAM_TRP + 5;
    localparam int LIMIT   = NUM_REQ * REQ_CYC * 2;

    logic                 CLKx2;
    logic                 nRST;
    logic                 req;
    dram_pkg::host_req_s  req_data;
    logic                 busy;
    logic                 done;
    logic                 load;
    dram_pkg::dq_t        rdata;
    dram_pkg::dram_pins_s pins;
    dram_pkg::dq_bus_s    bus;
    dram_pkg::dq_t        dq_in;
    logic                 dqs_in;
    dram_pkg::dram_cmd_e  cmd_seen;
    int                   store_cnt;
    dram_pkg::col_t       last_beat;
    dram_pkg::dq_t        last_word;

    dram_pkg::dq_t        shadow [logic [ADDR_W-1:0]];
    dram_pkg::host_req_s  cur;
    dram_pkg::host_req_s  ghost;
    dram_pkg::host_req_s  wr_list [$];
    dram_pkg::dq_t        exp_word;
    int                   errors = 0;
    int                   checks = 0;
    int                   cycles = 0;
    int                   cmd_step = 0;
    int                   act_cnt = 0;
    int                   done_cnt = 0;
    int                   load_cnt = 0;
    // Strobe toggles seen while the PHY drives DQS
    int                   dqs_toggles = 0;
    logic                 dqs_last = 1'b0;
    logic                 dqs_oe_last = 1'b0;

    dram_phy_top i_dut (
        .CLKx2   (CLKx2),
        .nRST    (nRST),
        .req     (req),
        .req_data(req_data),
        .busy    (busy),
        .done    (done),
        .rdata   (rdata),
        .load    (load),
        .pins    (pins),
        .bus     (bus),
        .dq_in   (dq_in),
        .dqs_in  (dqs_in)
    );

    dram_model i_model (
        .CLKx2    (CLKx2),
        .nRST     (nRST),
        .pins     (pins),
        .bus      (bus),
        .dq_in    (dq_in),
        .dqs_in   (dqs_in),
        .cmd_seen (cmd_seen),
        .store_cnt(store_cnt),
        .last_beat(last_beat),
        .last_word(last_word)
    );

    initial begin
        CLKx2 = 1'b0;
        forever #50 CLKx2 = ~CLKx2;
    end

    // Shadow memory, a write stores the word and a read returns what is stored
    function automatic dram_pkg::dq_t ref_access(input dram_pkg::host_req_s r);
        logic [ADDR_W-1:0] addr;
        addr = {r.bank, r.row, r.col};
        if (r.write) begin
            shadow[addr] = r.wdata;
        end
        return shadow.exists(addr) ? shadow[addr] : '0;
    endfunction

    function automatic dram_pkg::host_req_s random_req(input logic write);
        dram_pkg::host_req_s r;
        r.write = write;
        r.bank  = dram_pkg::bank_t'($urandom);
        r.row   = dram_pkg::row_t'($urandom);
        r.col   = dram_pkg::col_t'($urandom);
        r.wdata = $urandom;
        return r;
    endfunction

    task automatic expect_true(input logic ok, input string msg);
        checks++;
        assert (ok) else begin
            errors++;
            $display("Error at %0d ns: %s", $time, msg);
        end
    endtask

    task automatic check_idle_outputs();
        expect_true(!bus.dq_oe && !bus.dqs_oe && bus.dm_n,
                    "data path drives the bus or masks DM while idle");
        expect_true(!load && !done && !busy, "load, done or busy high while idle");
        expect_true(!i_dut.xfer.wr_en && !i_dut.xfer.rd_en, "data window open while idle");
        expect_true(pins.cs_n && pins.act_n && pins.ras_n && pins.cas_n && pins.we_n,
                    "command pins not at NOP while idle");
    endtask

    // Issues one request and waits for done, optionally poking req while busy
    task automatic run_request(input dram_pkg::host_req_s r, input logic poke);
        int stores0;
        int loads0;
        int toggles0;
        stores0  = store_cnt;
        loads0   = load_cnt;
        toggles0 = dqs_toggles;
        @(posedge CLKx2);
        cur = r;
        if (r.write) begin
            void'(ref_access(r));
        end
        req      <= 1'b1;
        req_data <= r;
        @(posedge CLKx2);
        req <= 1'b0;
        if (poke) begin
            ghost = random_req(1'b1);
            repeat (3) @(posedge CLKx2);
            expect_true(busy, "busy low in the middle of a request");
            req      <= 1'b1;
            req_data <= ghost;
            @(posedge CLKx2);
            req <= 1'b0;
        end
        do @(posedge CLKx2); while (!done);
        expect_true(!busy, "busy still high with done");
        if (r.write) begin
            expect_true(store_cnt == stores0 + 1 && last_beat == r.col &&
                        last_word == r.wdata,
                        $sformatf("stored %0d beats, last %0d %h, expected col %0d %h",
                                  store_cnt - stores0, last_beat, last_word, r.col, r.wdata));
            expect_true(dqs_toggles - toggles0 >= `DRAM_BURST,
                        $sformatf("write toggled DQS %0d times", dqs_toggles - toggles0));
        end else begin
            expect_true(load_cnt == loads0 + 1,
                        $sformatf("read gave %0d load pulses", load_cnt - loads0));
        end
    endtask

    // Command order, done pulses, strobe and read data
    always @(posedge CLKx2) begin
        if (nRST) begin
            case (cmd_seen)
                dram_pkg::ACT: begin
                    act_cnt++;
                    expect_true(cmd_step == 0 && pins.bank == cur.bank && pins.addr == cur.row,
                                $sformatf("ACT at step %0d bank %0d row %h, expected bank %0d row %h",
                                          cmd_step, pins.bank, pins.addr, cur.bank, cur.row));
                    cmd_step = 1;
                end
                dram_pkg::RD, dram_pkg::WR: begin
                    expect_true(cmd_step == 1 && pins.bank == cur.bank &&
                                (cmd_seen == dram_pkg::WR) == cur.write,
                                $sformatf("%s at step %0d bank %0d", cmd_seen.name(), cmd_step,
                                          pins.bank));
                    cmd_step = 2;
                end
                dram_pkg::PRE: begin
                    expect_true(cmd_step == 2 && pins.bank == cur.bank,
                                $sformatf("PRE at step %0d bank %0d", cmd_step, pins.bank));
                    cmd_step = 3;
                end
                default: ;
            endcase
            if (done) begin
                done_cnt++;
                expect_true(cmd_step == 3, $sformatf("done at command step %0d", cmd_step));
                cmd_step = 0;
            end
            if (bus.dqs_oe) begin
                expect_true(bus.dqs_c == ~bus.dqs_t, "DQS complement is not the inverse of DQS");
                if (dqs_oe_last && bus.dqs_t[0] != dqs_last) begin
                    dqs_toggles++;
                end
            end
            dqs_last    = bus.dqs_t[0];
            dqs_oe_last = bus.dqs_oe;
            if (load) begin
                load_cnt++;
                exp_word = ref_access(cur);
                expect_true(!cur.write && rdata == exp_word,
                            $sformatf("rdata %h, expected %h at bank %0d row %h col %0d",
                                      rdata, exp_word, cur.bank, cur.row, cur.col));
            end
        end
    end

    always @(posedge CLKx2) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", LIMIT);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        dram_pkg::host_req_s r;
        void'($urandom(32'hb84e_0af0));
        nRST     = 1'b0;
        req      = 1'b0;
        req_data = '0;
        repeat (5) @(posedge CLKx2);
        check_idle_outputs();
        nRST <= 1'b1;
        @(posedge CLKx2);
        check_idle_outputs();

        // Last write lands on the first address again
        for (int i = 0; i < NUM_WR; i++) begin
            r = random_req(1'b1);
            if (i == NUM_WR - 1) begin
                r       = wr_list[0];
                r.wdata = $urandom;
            end
            wr_list.push_back(r);
            run_request(r, 1'b0);
        end

        // Written positions alternate with random, mostly empty ones
        for (int i = 0; i < NUM_RD; i++) begin
            if (i % 2 == 0) begin
                r = wr_list[(i / 2) % wr_list.size()];
            end else begin
                r = random_req(1'b0);
            end
            r.write = 1'b0;
            run_request(r, i == 1);
        end

        // The write that came in while busy must not be in memory
        r       = ghost;
        r.write = 1'b0;
        run_request(r, 1'b0);

        repeat (4) @(posedge CLKx2);
        expect_true(act_cnt == NUM_REQ && done_cnt == NUM_REQ,
                    $sformatf("%0d ACT and %0d done for %0d requests",
                              act_cnt, done_cnt, NUM_REQ));
        $display("Checks: %0d, errors: %0d, requests: %0d", checks, errors, done_cnt);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/dram_model.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dram_defines.svh"

module dram_model (
    input  wire logic                 CLKx2,
    input  wire logic                 nRST,
    input  wire dram_pkg::dram_pins_s pins,
    input  wire dram_pkg::dq_bus_s    bus,
    output dram_pkg::dq_t             dq_in,
    output logic                      dqs_in,
    output dram_pkg::dram_cmd_e       cmd_seen,
    output int                        store_cnt,
    output dram_pkg::col_t            last_beat,
    output dram_pkg::dq_t             last_word
);

    localparam int ADDR_W = `DRAM_BANK_W + `DRAM_ROW_W + `DRAM_COL_W;

    dram_pkg::dq_t   mem [logic [ADDR_W-1:0]];
    dram_pkg::row_t  open_row [1 << `DRAM_BANK_W];
    dram_pkg::bank_t wr_bank;
    dram_pkg::bank_t rd_bank;
    dram_pkg::dq_t   dq_drv;
    logic            dqs_drv;
    int              wr_pos;
    int              rd_pos;
    int              wr_beat;
    int              rd_beat;

    // Unwritten locations read as zero
    function automatic dram_pkg::dq_t read_word(input logic [ADDR_W-1:0] addr);
        return mem.exists(addr) ? mem[addr] : '0;
    endfunction

    always_comb begin
        if (pins.cs_n) begin
            cmd_seen = dram_pkg::NOP;
        end else if (!pins.act_n) begin
            cmd_seen = dram_pkg::ACT;
        end else if (!pins.cas_n) begin
            cmd_seen = pins.we_n ? dram_pkg::RD : dram_pkg::WR;
        end else if (!pins.ras_n && !pins.we_n) begin
            cmd_seen = dram_pkg::PRE;
        end else begin
            cmd_seen = dram_pkg::NOP;
        end
    end

    // Bus resolution, the PHY wins while it drives
    assign dq_in  = bus.dq_oe ? bus.dq_out : dq_drv;
    assign dqs_in = bus.dqs_oe ? bus.dqs_t[0] : dqs_drv;

    always @(posedge CLKx2 or negedge nRST) begin
        if (!nRST) begin
            wr_pos    <= 0;
            rd_pos    <= 0;
            dqs_drv   <= 1'b0;
            dq_drv    <= '0;
            store_cnt <= 0;
            last_beat <= '0;
            last_word <= '0;
        end else begin
            // DQ and DM settle on the falling edge, so the rising edge sees a stable beat
            wr_beat = wr_pos - `DRAM_CWL;
            if (bus.dq_oe && bus.dm_n) begin
                store_cnt <= store_cnt + 1;
                last_beat <= dram_pkg::col_t'(wr_beat);
                last_word <= bus.dq_out;
                if (wr_pos > 0 && wr_beat >= 0 && wr_beat < `DRAM_BURST) begin
                    mem[{wr_bank, open_row[wr_bank], dram_pkg::col_t'(wr_beat)}] = bus.dq_out;
                end
            end
            if (wr_pos > 0) begin
                wr_pos <= (wr_beat < `DRAM_BURST - 1) ? wr_pos + 1 : 0;
            end
            // One preamble cycle, then a strobe toggle and a new word per cycle
            rd_beat = rd_pos - `DRAM_CL - 1;
            if (rd_pos > 0) begin
                if (rd_beat >= 0) begin
                    dqs_drv <= ~dqs_drv;
                    dq_drv  <= read_word({rd_bank, open_row[rd_bank],
                                          dram_pkg::col_t'(rd_beat)});
                end
                rd_pos <= (rd_beat < `DRAM_BURST - 1) ? rd_pos + 1 : 0;
            end
            case (cmd_seen)
                dram_pkg::ACT: open_row[pins.bank] <= pins.addr;
                dram_pkg::WR: begin
                    wr_bank <= pins.bank;
                    wr_pos  <= 1;
                end
                dram_pkg::RD: begin
                    rd_bank <= pins.bank;
                    rd_pos  <= 1;
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/dram_phy_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dram_defines.svh"

module dram_phy_top (
    input  logic                 CLKx2,
    input  logic                 nRST,
    input  logic                 req,
    input  dram_pkg::host_req_s  req_data,
    output logic                 busy,
    output logic                 done,
    output dram_pkg::dq_t        rdata,
    output logic                 load,
    output dram_pkg::dram_pins_s pins,
    output dram_pkg::dq_bus_s    bus,
    input  dram_pkg::dq_t        dq_in,
    input  logic                 dqs_in
);

    dram_pkg::dram_cmd_e  cmd;
    dram_pkg::bank_t      cmd_bank;
    dram_pkg::row_t       cmd_row;
    dram_pkg::xfer_ctrl_s xfer;

    dram_ctrl i_ctrl (
        .CLKx2   (CLKx2),
        .nRST    (nRST),
        .req     (req),
        .req_data(req_data),
        .busy    (busy),
        .done    (done),
        .cmd     (cmd),
        .cmd_bank(cmd_bank),
        .cmd_row (cmd_row),
        .xfer    (xfer)
    );

    dram_cmd_enc i_cmd_enc (
        .CLKx2(CLKx2),
        .nRST (nRST),
        .cmd  (cmd),
        .bank (cmd_bank),
        .row  (cmd_row),
        .pins (pins)
    );

    // Write word comes straight from the host, held stable while busy
    data_transfer i_data (
        .CLKx2 (CLKx2),
        .nRST  (nRST),
        .xfer  (xfer),
        .wdata (req_data.wdata),
        .dq_in (dq_in),
        .dqs_in(dqs_in),
        .bus   (bus),
        .rdata (rdata),
        .load  (load)
    );

endmodule

`default_nettype wire

/* src/data_transfer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dram_defines.svh"

module data_transfer (
    input  logic                 CLKx2,
    input  logic                 nRST,
    input  dram_pkg::xfer_ctrl_s xfer,
    input  dram_pkg::dq_t        wdata,
    input  dram_pkg::dq_t        dq_in,
    input  logic                 dqs_in,
    output dram_pkg::dq_bus_s    bus,
    output dram_pkg::dq_t        rdata,
    output logic                 load
);

    localparam dram_pkg::beat_cnt_t BURST     = dram_pkg::beat_cnt_t'(`DRAM_BURST);
    localparam dram_pkg::beat_cnt_t BEAT_OFFS = 4'd3;

    dram_pkg::beat_cnt_t wr_cnt;
    dram_pkg::beat_cnt_t beat_idx;
    dram_pkg::beat_cnt_t cap_idx;
    logic                in_burst;
    logic                beat_match;
    logic                dqs_q;
    logic                dm_q;
    logic                dqs_flag;
    dram_pkg::dq_t       dq_q;
    dram_pkg::dq_t       dq_d1;
    dram_pkg::dq_t       dq_d2;
    dram_pkg::dq_t       cap_mem [`DRAM_BURST];

    // Write side
    assign beat_idx   = wr_cnt - BEAT_OFFS;
    assign in_burst   = (wr_cnt >= BEAT_OFFS) && (wr_cnt < BEAT_OFFS + BURST);
    assign beat_match = in_burst && (beat_idx == dram_pkg::beat_cnt_t'(xfer.col));

    always_ff @(posedge CLKx2 or negedge nRST) begin
        if (!nRST) begin
            wr_cnt <= '0;
            dqs_q  <= 1'b0;
        end else if (xfer.clear) begin
            wr_cnt <= '0;
            dqs_q  <= 1'b0;
        end else if (xfer.wr_en) begin
            wr_cnt <= wr_cnt + 4'd1;
            // Strobe runs from count 2 until the last beat
            if (wr_cnt >= 4'd2 && wr_cnt < BEAT_OFFS + BURST) begin
                dqs_q <= ~dqs_q;
            end
        end
    end

    // DQ and DM change on the falling edge, centered on DQS
    always_ff @(negedge CLKx2 or negedge nRST) begin
        if (!nRST) begin
            dq_q <= '0;
            dm_q <= 1'b1;
        end else begin
            if (xfer.wr_en && wr_cnt >= BEAT_OFFS) begin
                dq_q <= wdata;
            end
            dm_q <= xfer.wr_en ? beat_match : 1'b1;
        end
    end

    always_comb begin
        bus.dq_out = dq_q;
        bus.dq_oe  = xfer.wr_en;
        bus.dqs_t  = {`DRAM_DQS_W{dqs_q}};
        bus.dqs_c  = {`DRAM_DQS_W{~dqs_q}};
        bus.dqs_oe = xfer.wr_en;
        bus.dm_n   = dm_q;
    end

    // Read side
    edge_det #(
        .TRIG_RISE(1'b1),
        .TRIG_FALL(1'b1)
    ) i_dqs_edge (
        .CLKx2    (CLKx2),
        .nRST     (nRST),
        .async_in (dqs_in),
        .edge_flag(dqs_flag)
    );

    // Same two stages as the strobe synchronizer
    always_ff @(posedge CLKx2) begin
        dq_d1 <= dq_in;
        dq_d2 <= dq_d1;
        if (xfer.rd_en && dqs_flag && cap_idx < BURST) begin
            cap_mem[cap_idx[`DRAM_COL_W-1:0]] <= dq_d2;
        end
    end

    always_ff @(posedge CLKx2 or negedge nRST) begin
        if (!nRST) begin
            cap_idx <= '0;
            load    <= 1'b0;
        end else begin
            load <= xfer.rd_en && dqs_flag && (cap_idx == BURST - 4'd1);
            if (xfer.clear) begin
                cap_idx <= '0;
            end else if (xfer.rd_en && dqs_flag && cap_idx < BURST) begin
                cap_idx <= cap_idx + 4'd1;
            end
        end
    end

    // Burst is complete when load fires
    assign rdata = cap_mem[xfer.col];

endmodule

`default_nettype wire

/* src/dram_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dram_defines.svh"

module dram_ctrl (
    input  logic                 CLKx2,
    input  logic                 nRST,
    input  logic                 req,
    input  dram_pkg::host_req_s  req_data,
    output logic                 busy,
    output logic                 done,
    output dram_pkg::dram_cmd_e  cmd,
    output dram_pkg::bank_t      cmd_bank,
    output dram_pkg::row_t       cmd_row,
    output dram_pkg::xfer_ctrl_s xfer
);

    localparam int WR_WIN = `DRAM_CWL + `DRAM_BURST + 3;

    dram_pkg::ctrl_state_e state;
    logic [4:0]            wait_cnt;

    // Latched request fields
    logic                  wr_q;
    dram_pkg::bank_t       bank_q;
    dram_pkg::row_t        row_q;
    dram_pkg::col_t        col_q;

    always_ff @(posedge CLKx2 or negedge nRST) begin
        if (!nRST) begin
            state    <= dram_pkg::IDLE;
            wait_cnt <= '0;
            busy     <= 1'b0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                dram_pkg::IDLE: begin
                    if (req) begin
                        state <= dram_pkg::ACTIVATE;
                        busy  <= 1'b1;
                    end
                end
                dram_pkg::ACTIVATE: begin
                    state    <= dram_pkg::TRCD_WAIT;
                    wait_cnt <= 5'(`DRAM_TRCD - 1);
                end
                dram_pkg::TRCD_WAIT: begin
                    if (wait_cnt == '0) begin
                        state <= dram_pkg::ISSUE;
                    end else begin
                        wait_cnt <= wait_cnt - 5'd1;
                    end
                end
                dram_pkg::ISSUE: begin
                    state    <= dram_pkg::DATA;
                    // Write window is fixed, read window allows for the sync delay
                    wait_cnt <= wr_q ? 5'(WR_WIN - 1) : 5'(`DRAM_RD_WIN - 1);
                end
                dram_pkg::DATA: begin
                    if (wait_cnt == '0) begin
                        state <= dram_pkg::PRECHARGE;
                    end else begin
                        wait_cnt <= wait_cnt - 5'd1;
                    end
                end
                dram_pkg::PRECHARGE: begin
                    state    <= dram_pkg::TRP_WAIT;
                    wait_cnt <= 5'(`DRAM_TRP - 1);
                end
                dram_pkg::TRP_WAIT: begin
                    if (wait_cnt == '0) begin
                        state <= dram_pkg::IDLE;
                        busy  <= 1'b0;
                        done  <= 1'b1;
                    end else begin
                        wait_cnt <= wait_cnt - 5'd1;
                    end
                end
                default: state <= dram_pkg::IDLE;
            endcase
        end
    end

    // Request is only taken in IDLE
    always_ff @(posedge CLKx2) begin
        if (state == dram_pkg::IDLE && req) begin
            wr_q   <= req_data.write;
            bank_q <= req_data.bank;
            row_q  <= req_data.row;
            col_q  <= req_data.col;
        end
    end

    always_comb begin
        case (state)
            dram_pkg::ACTIVATE:  cmd = dram_pkg::ACT;
            dram_pkg::ISSUE:     cmd = wr_q ? dram_pkg::WR : dram_pkg::RD;
            dram_pkg::PRECHARGE: cmd = dram_pkg::PRE;
            default:             cmd = dram_pkg::NOP;
        endcase
    end

    assign cmd_bank = bank_q;
    assign cmd_row  = row_q;

    always_comb begin
        xfer.wr_en = (state == dram_pkg::DATA) && wr_q;
        xfer.rd_en = (state == dram_pkg::DATA) && !wr_q;
        xfer.clear = (state == dram_pkg::ISSUE);
        xfer.col   = col_q;
    end

endmodule

`default_nettype wire

/* src/dram_cmd_enc.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dram_defines.svh"

module dram_cmd_enc (
    input  logic                 CLKx2,
    input  logic                 nRST,
    input  dram_pkg::dram_cmd_e  cmd,
    input  dram_pkg::bank_t      bank,
    input  dram_pkg::row_t       row,
    output dram_pkg::dram_pins_s pins
);

    dram_pkg::dram_pins_s pins_d;

    always_comb begin
        // Deselect by default
        pins_d.cs_n  = 1'b1;
        pins_d.act_n = 1'b1;
        pins_d.ras_n = 1'b1;
        pins_d.cas_n = 1'b1;
        pins_d.we_n  = 1'b1;
        pins_d.bank  = '0;
        pins_d.addr  = '0;
        case (cmd)
            dram_pkg::ACT: begin
                pins_d.cs_n  = 1'b0;
                pins_d.act_n = 1'b0;
                pins_d.bank  = bank;
                pins_d.addr  = row;
            end
            // Burst always starts at beat 0, so the column stays zero
            dram_pkg::RD: begin
                pins_d.cs_n  = 1'b0;
                pins_d.cas_n = 1'b0;
                pins_d.bank  = bank;
            end
            dram_pkg::WR: begin
                pins_d.cs_n  = 1'b0;
                pins_d.cas_n = 1'b0;
                pins_d.we_n  = 1'b0;
                pins_d.bank  = bank;
            end
            dram_pkg::PRE: begin
                pins_d.cs_n  = 1'b0;
                pins_d.ras_n = 1'b0;
                pins_d.we_n  = 1'b0;
                pins_d.bank  = bank;
            end
            default: ;
        endcase
    end

    always_ff @(posedge CLKx2 or negedge nRST) begin
        if (!nRST) begin
            pins <= '{cs_n: 1'b1, act_n: 1'b1, ras_n: 1'b1, cas_n: 1'b1,
                      we_n: 1'b1, bank: '0, addr: '0};
        end else begin
            pins <= pins_d;
        end
    end

endmodule

`default_nettype wire

/* src/edge_det.sv */
`timescale 1ns/1ps
`default_nettype none

module edge_det #(
    parameter bit TRIG_RISE = 1'b1,
    parameter bit TRIG_FALL = 1'b0
) (
    input  logic CLKx2,
    input  logic nRST,
    input  logic async_in,
    output logic edge_flag
);

    logic sync1;
    logic sync2;
    logic prev;

    always_ff @(posedge CLKx2 or negedge nRST) begin
        if (!nRST) begin
            sync1 <= 1'b0;
            sync2 <= 1'b0;
            prev  <= 1'b0;
        end else begin
            sync1 <= async_in;
            sync2 <= sync1;
            prev  <= sync2;
        end
    end

    // Flag is high for the one cycle after sync2 changes
    assign edge_flag = (TRIG_RISE && sync2 && !prev) ||
                       (TRIG_FALL && !sync2 && prev);

endmodule

`default_nettype wire

/* src/dram_pkg.sv */
`default_nettype none

`include "dram_defines.svh"

package dram_pkg;

    typedef logic [`DRAM_DQ_W-1:0]   dq_t;
    typedef logic [`DRAM_ROW_W-1:0]  row_t;
    typedef logic [`DRAM_BANK_W-1:0] bank_t;
    typedef logic [`DRAM_COL_W-1:0]  col_t;
    typedef logic [3:0]              beat_cnt_t;

    typedef enum logic [2:0] {
        NOP,
        ACT,
        RD,
        WR,
        PRE
    } dram_cmd_e;

    typedef enum logic [2:0] {
        IDLE,
        ACTIVATE,
        TRCD_WAIT,
        ISSUE,
        DATA,
        PRECHARGE,
        TRP_WAIT
    } ctrl_state_e;

    // One host access, 50 bits
    typedef struct packed {
        logic  write;
        bank_t bank;
        row_t  row;
        col_t  col;
        dq_t   wdata;
    } host_req_s;

    typedef struct packed {
        logic wr_en;
        logic rd_en;
        logic clear;
        col_t col;
    } xfer_ctrl_s;

    // Command bus, all control lines active low
    typedef struct packed {
        logic  cs_n;
        logic  act_n;
        logic  ras_n;
        logic  cas_n;
        logic  we_n;
        bank_t bank;
        row_t  addr;
    } dram_pins_s;

    typedef struct packed {
        dq_t                   dq_out;
        logic                  dq_oe;
        logic [`DRAM_DQS_W-1:0] dqs_t;
        logic [`DRAM_DQS_W-1:0] dqs_c;
        logic                  dqs_oe;
        logic                  dm_n;
    } dq_bus_s;

endpackage

`default_nettype wire

/* src/dram_defines.svh */
`ifndef DRAM_DEFINES_SVH
`define DRAM_DEFINES_SVH

// Burst and bus widths
`define DRAM_BURST   8
`define DRAM_DQ_W    32
`define DRAM_DQS_W   1
`define DRAM_ROW_W   12
`define DRAM_BANK_W  2
`define DRAM_COL_W   3

// Command timing in CLKx2 cycles
`define DRAM_TRCD    3
`define DRAM_CL      4
`define DRAM_CWL     3
`define DRAM_TRP     2

// Read window covers latency, burst and the sync pipeline
`define DRAM_RD_WIN  (`DRAM_CL + `DRAM_BURST + 6)

`endif
